//--- Bender.yml
package:
  name: miss_handler

export_include_dirs:
  - source

sources:
  - source/miss_handler_pkg.sv
  - source/miss_fifo.sv
  - source/miss_req_path.sv
  - source/refill_resp_buffer.sv
  - source/refill_ctrl.sv
  - source/miss_handler.sv
  - target: test
    files:
      - tb/tb_miss_handler.sv

//--- source/miss_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register FIFO with full and empty flags
// Used for bank misses and for refill response buffering
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module miss_fifo #(
    parameter int DEPTH = 2,
    parameter int WIDTH = 8
) (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             push_i,
    output logic             full_o,
    input  logic [WIDTH-1:0] wdata_i,
    input  logic             pop_i,
    output logic             empty_o,
    output logic [WIDTH-1:0] rdata_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;

    // Wrap at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop_i) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            if (push_i && !pop_i) begin
                count_q <= count_q + 1'b1;
            end else if (pop_i && !push_i) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= wdata_i;
        end
    end

    assign full_o  = (count_q == CNT_W'(DEPTH));
    assign empty_o = (count_q == '0);
    assign rdata_o = mem_q[rd_ptr_q];

    a_no_push_when_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
        push_i |-> !full_o)
        else $error("miss_fifo: push while full");

    a_no_pop_when_empty : assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_i |-> !empty_o)
        else $error("miss_fifo: pop while empty");

endmodule

//--- source/miss_handler.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cache miss handler top level
// Request path, response buffer and refill controller
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "miss_handler_settings.svh"

module miss_handler
    import miss_handler_pkg::*;
(
    input  logic                        clk_i,
    input  logic                        rst_ni,
    // Bank misses
    input  logic      [`MH_N_BANKS-1:0] miss_valid_i,
    output logic      [`MH_N_BANKS-1:0] miss_ready_o,
    input  miss_req_t [`MH_N_BANKS-1:0] miss_req_i,
    // Memory request
    output logic                        mem_req_valid_o,
    input  logic                        mem_req_ready_i,
    output mem_req_t                    mem_req_o,
    // Memory response
    input  logic                        mem_resp_valid_i,
    input  mem_resp_t                   mem_resp_i,
    output logic                        mem_resp_ready_o,
    // Refill towards the banks
    output logic      [`MH_N_BANKS-1:0] refill_req_valid_o,
    input  logic      [`MH_N_BANKS-1:0] refill_req_ready_i,
    output logic      [`MH_N_BANKS-1:0] refill_write_data_o,
    output logic      [`MH_N_BANKS-1:0] refill_write_dir_o,
    output logic      [`MH_N_BANKS-1:0] refill_updt_rtab_o,
    output refill_t                     refill_o,
    // MSHR acknowledge
    output logic      [`MH_N_BANKS-1:0] mshr_ack_o,
    output logic      [`MH_N_BANKS-1:0] mshr_ack_cs_o,
    output mshr_id_t                    mshr_ack_id_o
);

    logic       meta_valid;
    resp_meta_t meta;
    logic       meta_pop;
    word_t      data;
    logic       data_pop;

    miss_req_path i_req_path (
        .clk_i,
        .rst_ni,
        .miss_valid_i,
        .miss_ready_o,
        .miss_req_i,
        .mem_req_valid_o,
        .mem_req_ready_i,
        .mem_req_o
    );

    refill_resp_buffer i_resp_buffer (
        .clk_i,
        .rst_ni,
        .mem_resp_valid_i,
        .mem_resp_i,
        .mem_resp_ready_o,
        .meta_valid_o (meta_valid),
        .meta_o       (meta),
        .meta_pop_i   (meta_pop),
        .data_o       (data),
        .data_pop_i   (data_pop)
    );

    refill_ctrl i_refill_ctrl (
        .clk_i,
        .rst_ni,
        .meta_valid_i (meta_valid),
        .meta_i       (meta),
        .meta_pop_o   (meta_pop),
        .data_i       (data),
        .data_pop_o   (data_pop),
        .refill_req_valid_o,
        .refill_req_ready_i,
        .refill_write_data_o,
        .refill_write_dir_o,
        .refill_updt_rtab_o,
        .refill_o,
        .mshr_ack_o,
        .mshr_ack_cs_o,
        .mshr_ack_id_o
    );

endmodule

//--- source/miss_handler_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types of the cache miss handler
// Miss request, memory ID union, memory request and response beat,
// buffered line metadata and refill output
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "miss_handler_settings.svh"

package miss_handler_pkg;

    typedef logic [`MH_BANK_W-1:0]                   bank_id_t;
    typedef logic [`MH_NLINE_W-1:0]                  nline_t;
    typedef logic [`MH_MSHR_ID_W-1:0]                mshr_id_t;
    typedef logic [`MH_WORD_W-1:0]                   word_t;
    typedef logic [`MH_WORD_IDX_W-1:0]               word_idx_t;
    typedef logic [`MH_NLINE_W+`MH_CL_OFFSET_W-1:0]  mem_addr_t;

    typedef struct packed {
        nline_t   nline;
        mshr_id_t mshr_id;
    } miss_req_t;

    // Bank number sits above the MSHR index
    typedef struct packed {
        bank_id_t bank;
        mshr_id_t mshr_id;
    } mem_id_fields_t;

    typedef union packed {
        logic [`MH_BANK_W+`MH_MSHR_ID_W-1:0] raw;
        mem_id_fields_t                      fields;
    } mem_id_u;

    typedef struct packed {
        mem_addr_t addr;
        mem_id_u   id;
    } mem_req_t;

    typedef struct packed {
        word_t   data;
        mem_id_u id;
        logic    error;
        logic    last;
    } mem_resp_t;

    typedef struct packed {
        mem_id_u id;
        logic    error;
    } resp_meta_t;

    typedef struct packed {
        word_t     data;
        word_idx_t word_idx;
        logic      error;
    } refill_t;

endpackage

//--- source/miss_handler_settings.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Size macros for the cache miss handler
// Banks, line and MSHR fields, word geometry and FIFO depths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef MISS_HANDLER_SETTINGS_SVH
`define MISS_HANDLER_SETTINGS_SVH

// Cache organisation
`define MH_N_BANKS     2
`define MH_BANK_W      1
`define MH_NLINE_W     10
`define MH_MSHR_ID_W   2

// Word and line geometry, memory beat is one cache word
`define MH_WORD_W      32
`define MH_CL_WORDS    4
`define MH_WORD_IDX_W  2
`define MH_CL_OFFSET_W 4

// Buffer depths
`define MH_MISS_FIFO_DEPTH 2
`define MH_META_FIFO_DEPTH 2
`define MH_DATA_FIFO_DEPTH 8

`endif

//--- source/miss_req_path.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Miss request path
// Per-bank miss FIFOs, fixed-priority bank arbiter (lowest bank wins)
// and the two-state memory request send machine
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "miss_handler_settings.svh"

module miss_req_path
    import miss_handler_pkg::*;
(
    input  logic                             clk_i,
    input  logic                             rst_ni,
    input  logic      [`MH_N_BANKS-1:0]      miss_valid_i,
    output logic      [`MH_N_BANKS-1:0]      miss_ready_o,
    input  miss_req_t [`MH_N_BANKS-1:0]      miss_req_i,
    output logic                             mem_req_valid_o,
    input  logic                             mem_req_ready_i,
    output mem_req_t                         mem_req_o
);

    typedef enum logic {
        SEND_IDLE = 1'b0,
        SEND_BUSY = 1'b1
    } send_state_e;

    send_state_e                   send_state_q, send_state_d;
    nline_t                        send_nline_q, send_nline_d;
    mem_id_u                       send_id_q, send_id_d;

    logic      [`MH_N_BANKS-1:0]   fifo_full;
    logic      [`MH_N_BANKS-1:0]   fifo_empty;
    logic      [`MH_N_BANKS-1:0]   fifo_pop;
    miss_req_t [`MH_N_BANKS-1:0]   fifo_rdata;
    logic      [`MH_N_BANKS-1:0]   pending;
    bank_id_t                      grant_idx;
    miss_req_t                     sel_req;

    for (genvar b = 0; b < `MH_N_BANKS; b++) begin : gen_bank_fifo
        miss_fifo #(
            .DEPTH (`MH_MISS_FIFO_DEPTH),
            .WIDTH ($bits(miss_req_t))
        ) i_miss_fifo (
            .clk_i,
            .rst_ni,
            .push_i  (miss_valid_i[b] & ~fifo_full[b]),
            .full_o  (fifo_full[b]),
            .wdata_i (miss_req_i[b]),
            .pop_i   (fifo_pop[b]),
            .empty_o (fifo_empty[b]),
            .rdata_o (fifo_rdata[b])
        );
    end

    assign miss_ready_o = ~fifo_full;
    assign pending      = ~fifo_empty;

    // Scan downwards so the lowest pending bank is the one kept
    always_comb begin
        grant_idx = '0;
        for (int b = `MH_N_BANKS - 1; b >= 0; b--) begin
            if (pending[b]) begin
                grant_idx = bank_id_t'(b);
            end
        end
    end

    assign sel_req = fifo_rdata[grant_idx];

    always_comb begin
        send_state_d    = send_state_q;
        send_nline_d    = send_nline_q;
        send_id_d       = send_id_q;
        fifo_pop        = '0;
        mem_req_valid_o = 1'b0;
        case (send_state_q)
            SEND_IDLE: begin
                if (|pending) begin
                    fifo_pop[grant_idx]      = 1'b1;
                    send_nline_d             = sel_req.nline;
                    send_id_d.fields.bank    = grant_idx;
                    send_id_d.fields.mshr_id = sel_req.mshr_id;
                    send_state_d             = SEND_BUSY;
                end
            end
            SEND_BUSY: begin
                mem_req_valid_o = 1'b1;
                if (mem_req_ready_i) begin
                    send_state_d = SEND_IDLE;
                end
            end
            default: begin
                send_state_d = SEND_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            send_state_q <= SEND_IDLE;
        end else begin
            send_state_q <= send_state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        send_nline_q <= send_nline_d;
        send_id_q    <= send_id_d;
    end

    // Whole line requested, offset always zero
    assign mem_req_o.addr = {send_nline_q, {`MH_CL_OFFSET_W{1'b0}}};
    assign mem_req_o.id   = send_id_q;

    a_req_stable_when_stalled : assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_o))
        else $error("miss_req_path: memory request changed while stalled");

endmodule

//--- source/refill_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Refill controller
// Idle/write FSM with word counter, bank permission request,
// MSHR acknowledge and bank data/directory write strobes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "miss_handler_settings.svh"

module refill_ctrl
    import miss_handler_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   meta_valid_i,
    input  resp_meta_t             meta_i,
    output logic                   meta_pop_o,
    input  word_t                  data_i,
    output logic                   data_pop_o,
    output logic [`MH_N_BANKS-1:0] refill_req_valid_o,
    input  logic [`MH_N_BANKS-1:0] refill_req_ready_i,
    output logic [`MH_N_BANKS-1:0] refill_write_data_o,
    output logic [`MH_N_BANKS-1:0] refill_write_dir_o,
    output logic [`MH_N_BANKS-1:0] refill_updt_rtab_o,
    output refill_t                refill_o,
    output logic [`MH_N_BANKS-1:0] mshr_ack_o,
    output logic [`MH_N_BANKS-1:0] mshr_ack_cs_o,
    output mshr_id_t               mshr_ack_id_o
);

    typedef enum logic {
        REFILL_IDLE  = 1'b0,
        REFILL_WRITE = 1'b1
    } refill_state_e;

    refill_state_e state_q, state_d;
    word_idx_t     cnt_q, cnt_d;
    bank_id_t      bank;

    // Owning bank and MSHR come back out of the memory ID
    assign bank          = meta_i.id.fields.bank;
    assign mshr_ack_id_o = meta_i.id.fields.mshr_id;

    always_comb begin
        state_d             = state_q;
        cnt_d               = cnt_q;
        meta_pop_o          = 1'b0;
        data_pop_o          = 1'b0;
        refill_req_valid_o  = '0;
        refill_write_data_o = '0;
        refill_write_dir_o  = '0;
        refill_updt_rtab_o  = '0;
        mshr_ack_o          = '0;
        mshr_ack_cs_o       = '0;
        case (state_q)
            REFILL_IDLE: begin
                if (meta_valid_i) begin
                    refill_req_valid_o[bank] = 1'b1;
                    mshr_ack_cs_o[bank]      = 1'b1;
                    if (refill_req_ready_i[bank]) begin
                        mshr_ack_o[bank] = 1'b1;
                        cnt_d            = '0;
                        state_d          = REFILL_WRITE;
                    end
                end
            end
            REFILL_WRITE: begin
                // Erroneous line keeps the bank data untouched
                refill_write_data_o[bank] = ~meta_i.error;
                data_pop_o                = 1'b1;
                cnt_d                     = cnt_q + 1'b1;
                if (cnt_q == word_idx_t'(`MH_CL_WORDS - 1)) begin
                    refill_write_dir_o[bank] = 1'b1;
                    refill_updt_rtab_o[bank] = 1'b1;
                    meta_pop_o               = 1'b1;
                    state_d                  = REFILL_IDLE;
                end
            end
            default: begin
                state_d = REFILL_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= REFILL_IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            cnt_q   <= cnt_d;
        end
    end

    assign refill_o.data     = data_i;
    assign refill_o.word_idx = cnt_q;
    assign refill_o.error    = meta_i.error;

    a_strobes_one_bank : assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(refill_req_valid_o | mshr_ack_o | refill_write_data_o |
                 refill_write_dir_o | refill_updt_rtab_o))
        else $error("refill_ctrl: strobes address more than one bank");

    // Directory write closes the line one line-length after the acknowledge
    a_ack_to_dir : assert property (@(posedge clk_i) disable iff (!rst_ni)
        |mshr_ack_o |-> ##`MH_CL_WORDS (refill_write_dir_o == $past(mshr_ack_o, `MH_CL_WORDS)))
        else $error("refill_ctrl: directory write out of step with acknowledge");

endmodule

//--- source/refill_resp_buffer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory response buffering
// Data FIFO for every beat, metadata FIFO for each completed line,
// and the response ready logic
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "miss_handler_settings.svh"

module refill_resp_buffer
    import miss_handler_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       mem_resp_valid_i,
    input  mem_resp_t  mem_resp_i,
    output logic       mem_resp_ready_o,
    output logic       meta_valid_o,
    output resp_meta_t meta_o,
    input  logic       meta_pop_i,
    output word_t      data_o,
    input  logic       data_pop_i
);

    logic       beat_accept;
    logic       meta_full;
    logic       meta_empty;
    logic       data_full;
    logic       data_empty;
    resp_meta_t meta_wdata;

    // A last beat also needs a metadata slot
    assign mem_resp_ready_o = mem_resp_valid_i & ~data_full &
                              (~mem_resp_i.last | ~meta_full);
    assign beat_accept      = mem_resp_valid_i & mem_resp_ready_o;

    assign meta_wdata.id    = mem_resp_i.id;
    assign meta_wdata.error = mem_resp_i.error;

    miss_fifo #(
        .DEPTH (`MH_META_FIFO_DEPTH),
        .WIDTH ($bits(resp_meta_t))
    ) i_meta_fifo (
        .clk_i,
        .rst_ni,
        .push_i  (beat_accept & mem_resp_i.last),
        .full_o  (meta_full),
        .wdata_i (meta_wdata),
        .pop_i   (meta_pop_i),
        .empty_o (meta_empty),
        .rdata_o (meta_o)
    );

    miss_fifo #(
        .DEPTH (`MH_DATA_FIFO_DEPTH),
        .WIDTH (`MH_WORD_W)
    ) i_data_fifo (
        .clk_i,
        .rst_ni,
        .push_i  (beat_accept),
        .full_o  (data_full),
        .wdata_i (mem_resp_i.data),
        .pop_i   (data_pop_i),
        .empty_o (data_empty),
        .rdata_o (data_o)
    );

    assign meta_valid_o = ~meta_empty;

    // A visible line always has its words buffered ahead of it
    a_meta_has_data : assert property (@(posedge clk_i) disable iff (!rst_ni)
        meta_valid_o |-> !data_empty)
        else $error("refill_resp_buffer: metadata without buffered data");

endmodule

//--- tb/tb_miss_handler.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the cache miss handler
// Clock, reset, miss stimulus, behavioral memory, refill monitor,
// assertion checks, watchdog and result reporting
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "miss_handler_settings.svh"

module tb_miss_handler
    import miss_handler_pkg::*;
();

    localparam int N_BANKS      = `MH_N_BANKS;
    localparam int LAST_WORD    = `MH_CL_WORDS - 1;
    localparam int N_RAND       = 16;
    localparam int N_STALL      = 6;
    localparam int N_MISSES     = 2 + N_RAND + N_STALL;
    localparam int MAX_LINES    = 32;
    localparam int STALL_CYCLES = 60;
    localparam int TIMEOUT      = N_MISSES * (`MH_CL_WORDS * 8 + 16) + STALL_CYCLES + 500;

    logic                      clk_i;
    logic                      rst_ni;
    logic      [N_BANKS-1:0]   miss_valid_i;
    logic      [N_BANKS-1:0]   miss_ready_o;
    miss_req_t [N_BANKS-1:0]   miss_req_i;
    logic                      mem_req_valid_o;
    logic                      mem_req_ready_i;
    mem_req_t                  mem_req_o;
    logic                      mem_resp_valid_i;
    mem_resp_t                 mem_resp_i;
    logic                      mem_resp_ready_o;
    logic      [N_BANKS-1:0]   refill_req_valid_o;
    logic      [N_BANKS-1:0]   refill_req_ready_i;
    logic      [N_BANKS-1:0]   refill_write_data_o;
    logic      [N_BANKS-1:0]   refill_write_dir_o;
    logic      [N_BANKS-1:0]   refill_updt_rtab_o;
    refill_t                   refill_o;
    logic      [N_BANKS-1:0]   mshr_ack_o;
    logic      [N_BANKS-1:0]   mshr_ack_cs_o;
    mshr_id_t                  mshr_ack_id_o;

    int       seed        = 32'h357a;
    int       errors      = 0;
    int       posted_cnt  = 0;
    int       done_cnt    = 0;
    int       mem_idx     = 0;
    int       ref_idx     = 0;
    logic     hold_grant  = 1'b0;
    logic     prio_armed  = 1'b0;
    logic     saw_req_stall  = 1'b0;
    logic     saw_resp_stall = 1'b0;
    mshr_id_t mshr_next [N_BANKS] = '{default: '0};

    // Posted misses by memory ID
    logic     posted_busy  [8] = '{default: 1'b0};
    nline_t   posted_nline [8];
    mem_id_u  req_id_q [$];

    // Lines as the memory answered them, in order
    mem_id_u  line_id   [MAX_LINES];
    logic     line_err  [MAX_LINES];
    logic [`MH_CL_WORDS-1:0][`MH_WORD_W-1:0] line_data [MAX_LINES];

    // Line being refilled
    logic                                    in_line  = 1'b0;
    word_idx_t                               word_cnt = '0;
    logic                                    cur_err  = 1'b0;
    logic [N_BANKS-1:0]                      cur_mask = '0;
    logic [`MH_CL_WORDS-1:0][`MH_WORD_W-1:0] cur_data;

    mem_id_u            exp_id;
    mem_addr_t          exp_addr;
    word_t              exp_word;
    logic [N_BANKS-1:0] exp_ack;
    logic [N_BANKS-1:0] exp_strobe;
    logic [N_BANKS-1:0] exp_dir;

    function automatic logic [N_BANKS-1:0] bank_mask(input bank_id_t b);
        return N_BANKS'(1) << b;
    endfunction

    assign exp_id     = line_id[ref_idx];
    assign exp_ack    = bank_mask(exp_id.fields.bank);
    assign exp_addr   = {posted_nline[mem_req_o.id.raw], {`MH_CL_OFFSET_W{1'b0}}};
    assign exp_word   = cur_data[word_cnt];
    assign exp_strobe = cur_err ? '0 : cur_mask;
    assign exp_dir    = (word_cnt == word_idx_t'(LAST_WORD)) ? cur_mask : '0;

    miss_handler uut (
        .clk_i,
        .rst_ni,
        .miss_valid_i,
        .miss_ready_o,
        .miss_req_i,
        .mem_req_valid_o,
        .mem_req_ready_i,
        .mem_req_o,
        .mem_resp_valid_i,
        .mem_resp_i,
        .mem_resp_ready_o,
        .refill_req_valid_o,
        .refill_req_ready_i,
        .refill_write_data_o,
        .refill_write_dir_o,
        .refill_updt_rtab_o,
        .refill_o,
        .mshr_ack_o,
        .mshr_ack_cs_o,
        .mshr_ack_id_o
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // Memory accepts requests at random
    initial begin
        mem_req_ready_i = 1'b0;
        forever begin
            @(posedge clk_i);
            mem_req_ready_i <= ($random(seed) & 3) != 0;
        end
    end

    // Bank grants at random, or held off by the stall phase
    initial begin
        refill_req_ready_i = '0;
        forever begin
            @(posedge clk_i);
            refill_req_ready_i <= hold_grant ? '0 : N_BANKS'($random(seed));
        end
    end

    // Behavioral memory, one line of beats per request, in order
    initial begin : memory_model
        mem_resp_t beat;
        mem_resp_valid_i = 1'b0;
        mem_resp_i       = '0;
        forever begin
            @(negedge clk_i);
            if (req_id_q.size() != 0) begin
                line_id[mem_idx]  = req_id_q.pop_front();
                line_err[mem_idx] = (mem_idx % 5) == 3;
                for (int w = 0; w < `MH_CL_WORDS; w++) begin
                    line_data[mem_idx][w] = $random(seed);
                end
                @(posedge clk_i);
                for (int w = 0; w < `MH_CL_WORDS; w++) begin
                    beat.data  = line_data[mem_idx][w];
                    beat.id    = line_id[mem_idx];
                    beat.error = line_err[mem_idx];
                    beat.last  = (w == LAST_WORD);
                    mem_resp_valid_i <= 1'b1;
                    mem_resp_i       <= beat;
                    do @(negedge clk_i); while (!mem_resp_ready_o);
                    @(posedge clk_i);
                end
                mem_resp_valid_i <= 1'b0;
                mem_idx++;
            end
        end
    end

    // Tracks posted misses, memory requests and the refill in progress
    always @(posedge clk_i) begin
        if (rst_ni) begin
            for (int b = 0; b < N_BANKS; b++) begin
                if (miss_valid_i[b] && miss_ready_o[b]) begin
                    posted_busy[{bank_id_t'(b), miss_req_i[b].mshr_id}]  <= 1'b1;
                    posted_nline[{bank_id_t'(b), miss_req_i[b].mshr_id}] <= miss_req_i[b].nline;
                end
            end
            if (&(miss_valid_i & miss_ready_o)) begin
                prio_armed <= 1'b1;
            end
            if (mem_req_valid_o && mem_req_ready_i) begin
                req_id_q.push_back(mem_req_o.id);
                prio_armed <= 1'b0;
            end
            if (mem_req_valid_o && !mem_req_ready_i) begin
                saw_req_stall <= 1'b1;
            end
            if (mem_resp_valid_i && !mem_resp_ready_o) begin
                saw_resp_stall <= 1'b1;
            end
            if (|mshr_ack_o) begin
                in_line  <= 1'b1;
                word_cnt <= '0;
                cur_mask <= exp_ack;
                cur_err  <= line_err[ref_idx];
                cur_data <= line_data[ref_idx];
                posted_busy[exp_id.raw] <= 1'b0;
                ref_idx  <= ref_idx + 1;
            end else if (in_line) begin
                word_cnt <= word_cnt + 1'b1;
                if (word_cnt == word_idx_t'(LAST_WORD)) begin
                    in_line  <= 1'b0;
                    done_cnt <= done_cnt + 1;
                end
            end
        end
    end

    a_reset_idle : assert property (@(posedge clk_i) !rst_ni |->
        !mem_req_valid_o && !mem_resp_ready_o && refill_req_valid_o == '0 &&
        mshr_ack_o == '0 && refill_write_data_o == '0 && &miss_ready_o)
        else begin
            errors++;
            $display("outputs are not idle during reset");
        end

    a_req_id : assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_valid_o && mem_req_ready_i |-> posted_busy[mem_req_o.id.raw])
        else begin
            errors++;
            $display("memory request carries the ID of no posted miss");
        end

    a_req_addr : assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_valid_o && mem_req_ready_i |-> mem_req_o.addr == exp_addr)
        else begin
            errors++;
            $display("ERR req_addr expected %h actual %h",
                     $sampled(exp_addr), $sampled(mem_req_o.addr));
        end

    a_req_prio : assert property (@(posedge clk_i) disable iff (!rst_ni)
        prio_armed && mem_req_valid_o && mem_req_ready_i |-> mem_req_o.id.fields.bank == '0)
        else begin
            errors++;
            $display("ERR req_prio expected 0 actual %0d", $sampled(mem_req_o.id.fields.bank));
        end

    a_req_hold : assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_o))
        else begin
            errors++;
            $display("memory request dropped or changed while stalled");
        end

    a_ack_line : assert property (@(posedge clk_i) disable iff (!rst_ni)
        |mshr_ack_o |-> {mshr_ack_o, mshr_ack_id_o} == {exp_ack, exp_id.fields.mshr_id})
        else begin
            errors++;
            $display("ERR mshr_ack expected %h actual %h",
                     $sampled({exp_ack, exp_id.fields.mshr_id}),
                     $sampled({mshr_ack_o, mshr_ack_id_o}));
        end

    a_ack_grant : assert property (@(posedge clk_i) disable iff (!rst_ni)
        |mshr_ack_o |-> (mshr_ack_o & refill_req_ready_i) == mshr_ack_o)
        else begin
            errors++;
            $display("MSHR acknowledged without a bank grant");
        end

    // Permission request and MSHR select go to the bank of the next buffered line
    a_req_bank : assert property (@(posedge clk_i) disable iff (!rst_ni)
        |(refill_req_valid_o | mshr_ack_cs_o) |->
            refill_req_valid_o == exp_ack && mshr_ack_cs_o == exp_ack)
        else begin
            errors++;
            $display("ERR refill_req expected %b actual %b/%b", $sampled(exp_ack),
                     $sampled(refill_req_valid_o), $sampled(mshr_ack_cs_o));
        end

    a_word_strobe : assert property (@(posedge clk_i) disable iff (!rst_ni)
        in_line |-> refill_write_data_o == exp_strobe)
        else begin
            errors++;
            $display("ERR write_strobe expected %b actual %b",
                     $sampled(exp_strobe), $sampled(refill_write_data_o));
        end

    a_word_idx : assert property (@(posedge clk_i) disable iff (!rst_ni)
        in_line |-> {refill_o.word_idx, refill_o.error} == {word_cnt, cur_err})
        else begin
            errors++;
            $display("ERR word_idx expected %h actual %h", $sampled({word_cnt, cur_err}),
                     $sampled({refill_o.word_idx, refill_o.error}));
        end

    a_word_data : assert property (@(posedge clk_i) disable iff (!rst_ni)
        in_line && !cur_err |-> refill_o.data == exp_word)
        else begin
            errors++;
            $display("ERR word_data expected %h actual %h",
                     $sampled(exp_word), $sampled(refill_o.data));
        end

    a_dir_write : assert property (@(posedge clk_i) disable iff (!rst_ni)
        in_line |-> refill_write_dir_o == exp_dir && refill_updt_rtab_o == exp_dir)
        else begin
            errors++;
            $display("ERR dir_write expected %b actual %b/%b", $sampled(exp_dir),
                     $sampled(refill_write_dir_o), $sampled(refill_updt_rtab_o));
        end

    a_idle_quiet : assert property (@(posedge clk_i) disable iff (!rst_ni)
        !in_line |-> (refill_write_data_o | refill_write_dir_o | refill_updt_rtab_o) == '0)
        else begin
            errors++;
            $display("bank write strobe outside a granted refill");
        end

    // Posts one miss on each masked bank in the same cycle
    task automatic post_misses(input logic [N_BANKS-1:0] mask);
        mem_id_u ids [N_BANKS];
        logic    busy;
        for (int b = 0; b < N_BANKS; b++) begin
            ids[b].fields.bank    = bank_id_t'(b);
            ids[b].fields.mshr_id = mshr_next[b];
        end
        do begin
            @(negedge clk_i);
            busy = 1'b0;
            for (int b = 0; b < N_BANKS; b++) begin
                busy = busy | (mask[b] & posted_busy[ids[b].raw]);
            end
        end while (busy);
        @(posedge clk_i);
        for (int b = 0; b < N_BANKS; b++) begin
            if (mask[b]) begin
                miss_valid_i[b] <= 1'b1;
                miss_req_i[b]   <= '{nline: nline_t'($random(seed)), mshr_id: mshr_next[b]};
                mshr_next[b]    = mshr_next[b] + 1'b1;
                posted_cnt++;
            end
        end
        do @(negedge clk_i); while ((miss_ready_o & mask) != mask);
        @(posedge clk_i);
        miss_valid_i <= '0;
    endtask

    task automatic wait_drain();
        while (done_cnt != posted_cnt) begin
            @(negedge clk_i);
        end
    endtask

    initial begin
        repeat (TIMEOUT) @(posedge clk_i);
        $display("watchdog expired with %0d of %0d misses refilled, %0d errors",
                 done_cnt, posted_cnt, errors);
        $display("sim failed");
        $finish;
    end

    initial begin
        rst_ni       = 1'b0;
        miss_valid_i = '0;
        miss_req_i   = '0;
        repeat (5) @(posedge clk_i);
        rst_ni <= 1'b1;
        repeat (2) @(posedge clk_i);
        // Both banks miss on one edge
        post_misses('1);
        for (int i = 0; i < N_RAND; i++) begin
            post_misses(bank_mask(bank_id_t'($random(seed))));
        end
        wait_drain();
        // Hold off the banks so responses back up
        hold_grant = 1'b1;
        for (int i = 0; i < N_STALL; i++) begin
            post_misses(bank_mask(bank_id_t'(i)));
        end
        repeat (STALL_CYCLES) @(negedge clk_i);
        hold_grant = 1'b0;
        wait_drain();
        if (!saw_req_stall) begin
            errors++;
            $display("memory never stalled a request");
        end
        if (!saw_resp_stall) begin
            errors++;
            $display("memory responses never backed up into full buffers");
        end
        $display("run done with %0d errors, %0d of %0d misses refilled",
                 errors, done_cnt, posted_cnt);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+source
source/miss_handler_pkg.sv
source/miss_fifo.sv
source/miss_req_path.sv
source/refill_resp_buffer.sv
source/refill_ctrl.sv
source/miss_handler.sv
tb/tb_miss_handler.sv
